/* Bender.yml */
package:
  name: pwm_timer

sources:
  - src/pwm_pkg.sv
  - src/pwm_register_file.sv
  - src/pwm_counter.sv
  - src/pwm_compare.sv
  - src/pwm_timer.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/pwm_timer_tb.sv

/* pwm_timer.f */
+incdir+sim
src/pwm_pkg.sv
src/pwm_register_file.sv
src/pwm_counter.sv
src/pwm_compare.sv
src/pwm_timer.sv
sim/pwm_timer_tb.sv

/* sim/pwm_timer_checks.svh */
//////////////////////////////////////////////////
// PWM timer testbench helpers
// LFSR source, threshold and counter model, and the
// typed compare tasks
//////////////////////////////////////////////////

`ifndef PWM_TIMER_CHECKS_SVH
`define PWM_TIMER_CHECKS_SVH

logic [31:0] lfsr_state = 32'ha5f88b8f;
int check_total = 0;
int error_total = 0;

// Model state, as it stands after the most recent rising edge
logic [COUNTER_WIDTH-1:0] model_shadow  [2*compare_channels];
logic [COUNTER_WIDTH-1:0] model_working [2*compare_channels];
logic [COUNTER_WIDTH-1:0] model_count;
logic [COUNTER_WIDTH-1:0] model_period;
logic [COUNTER_WIDTH-1:0] model_data;
logic [2:0]               model_sel;
logic                     model_run;
logic                     model_we;
logic                     model_wrap;
logic [compare_channels-1:0] model_low;
logic [compare_channels-1:0] model_high;

// Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
function automatic logic [COUNTER_WIDTH-1:0] lfsr_bits(input int count);
    logic [COUNTER_WIDTH-1:0] value;
    value = '0;
    for (int b = 0; b < count; b++) begin
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        value = {value[COUNTER_WIDTH-2:0], lfsr_state[0]};
    end
    return value;
endfunction

// Entries 0 to 2 are the low group, 3 to 5 the high group
function automatic logic model_hits(input int index);
    return model_we && (model_sel == index ||
                        (index < compare_channels && model_sel == sel_all_low) ||
                        (index >= compare_channels && model_sel == sel_all_high));
endfunction

// Advances the model by one rising edge, using the inputs the DUT samples there
task automatic model_step(input logic rst_n, input logic we, input logic [3:0] addr,
                          input logic [COUNTER_WIDTH-1:0] data);
    logic reload;
    reload = model_wrap && model_run;
    if (!rst_n) begin
        for (int i = 0; i < 2 * compare_channels; i++) begin
            model_shadow[i]  = {COUNTER_WIDTH{i[0]}};
            model_working[i] = {COUNTER_WIDTH{i[0]}};
        end
        model_count  = '0;
        model_period = '1;
        model_run    = 1'b0;
        model_we     = 1'b0;
        model_wrap   = 1'b0;
        model_low    = '0;
        model_high   = '0;
    end else begin
        for (int c = 0; c < compare_channels; c++) begin
            model_low[c]  = model_count < model_working[c];
            model_high[c] = model_count > model_working[c + compare_channels];
        end
        for (int i = 0; i < 2 * compare_channels; i++) begin
            if (!model_run && model_hits(i)) begin
                model_working[i] = model_data;
            end else if (reload) begin
                model_working[i] = model_shadow[i];
            end
            if (model_hits(i)) begin
                model_shadow[i] = model_data;
            end
        end
        model_wrap = model_run && model_count >= model_period;
        if (!model_run || model_count >= model_period) begin
            model_count = '0;
        end else begin
            model_count = model_count + 1'b1;
        end
        model_we = we && addr <= reg_all_high;
        if (model_we) begin
            model_sel  = addr[2:0];
            model_data = data;
        end
        if (we && addr == reg_period) begin
            model_period = data;
        end
        if (we && addr == reg_control) begin
            model_run = data[0];
        end
    end
endtask

task automatic check_match(input string name, input logic [compare_channels-1:0] expected,
                           input logic [compare_channels-1:0] actual);
    check_total++;
    if (actual !== expected) begin
        error_total++;
        $display("CHECK FAILED at %0t: %s expected %b actual %b", $time, name, expected, actual);
    end
endtask

task automatic check_count(input string name, input logic [COUNTER_WIDTH-1:0] expected,
                           input logic [COUNTER_WIDTH-1:0] actual);
    check_total++;
    if (actual !== expected) begin
        error_total++;
        $display("CHECK FAILED at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
    end
endtask

`endif

/* sim/pwm_timer_tb.sv */
//////////////////////////////////////////////////
// PWM timer testbench
// Applies a table of bus operations and checks the
// count and match outputs against a model each cycle
//////////////////////////////////////////////////

module pwm_timer_tb;

    import pwm_pkg::*;

    localparam int COUNTER_WIDTH = 16;
    localparam int wait_limit    = 64;

    typedef enum {op_write, op_idle, op_wait} tb_op_e;

    logic                        clock;
    logic                        reset;
    logic                        bus_we;
    pwm_reg_addr_e               bus_addr;
    logic [COUNTER_WIDTH-1:0]    bus_data;
    logic [COUNTER_WIDTH-1:0]    count_value;
    logic [compare_channels-1:0] match_low;
    logic [compare_channels-1:0] match_high;

    // For op_wait the count column is the target count_value
    tb_op_e                   table_op [$];
    logic [3:0]               table_addr [$];
    logic [COUNTER_WIDTH-1:0] table_data [$];
    int                       table_bits [$];
    int                       table_count [$];
    int                       table_test [$];

    `include "pwm_timer_checks.svh"

    pwm_timer #(
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) UUT (
        .clock      (clock),
        .reset      (reset),
        .bus_we     (bus_we),
        .bus_addr   (bus_addr),
        .bus_data   (bus_data),
        .count_value(count_value),
        .match_low  (match_low),
        .match_high (match_high)
    );

    always #2 clock = ~clock;

    // Outputs are checked mid-cycle, then the model takes the next edge
    always @(negedge clock) begin
        if (reset) begin
            check_count("count_value", model_count, count_value);
            check_match("match_low", model_low, match_low);
            check_match("match_high", model_high, match_high);
        end
        model_step(reset, bus_we, bus_addr, bus_data);
    end

    task automatic add_entry(input int test, input tb_op_e op, input logic [3:0] addr,
                             input logic [COUNTER_WIDTH-1:0] data, input int bits,
                             input int count);
        table_test.push_back(test);
        table_op.push_back(op);
        table_addr.push_back(addr);
        table_data.push_back(data);
        table_bits.push_back(bits);
        table_count.push_back(count);
    endtask

    task automatic apply_entry(input int i);
        logic [COUNTER_WIDTH-1:0] prev;
        int waited;
        case (table_op[i])
            op_write: begin
                @(posedge clock);
                bus_we   <= 1'b1;
                bus_addr <= pwm_reg_addr_e'(table_addr[i]);
                bus_data <= (table_bits[i] > 0) ? lfsr_bits(table_bits[i]) : table_data[i];
                @(posedge clock);
                bus_we   <= 1'b0;
            end
            op_idle: begin
                repeat (table_count[i]) @(posedge clock);
            end
            op_wait: begin
                // Waits until count_value changes into the target value
                waited = 0;
                @(negedge clock);
                do begin
                    prev = count_value;
                    @(negedge clock);
                    waited++;
                end while ((count_value != table_count[i] || prev == table_count[i]) &&
                           waited < wait_limit);
                if (count_value != table_count[i] || prev == table_count[i]) begin
                    error_total++;
                    $display("Timeout: count_value never reached %0d", table_count[i]);
                end
            end
        endcase
    endtask

    initial begin
        int test_errors;
        clock    = 1'b0;
        reset    = 1'b0;
        bus_we   = 1'b0;
        bus_addr = reg_low_0;
        bus_data = '0;
        add_entry(1, op_idle, 0, 0, 0, 6);
        add_entry(2, op_write, reg_low_1, 5, 0, 0);
        add_entry(2, op_idle, 0, 0, 0, 3);
        add_entry(2, op_write, reg_all_high, 3, 0, 0);
        add_entry(2, op_write, reg_all_low, 0, 0, 0);
        add_entry(2, op_write, reg_low_2, 7, 0, 0);
        add_entry(2, op_idle, 0, 0, 0, 4);
        add_entry(3, op_write, reg_period, 5, 0, 0);
        add_entry(3, op_write, reg_control, 1, 0, 0);
        add_entry(3, op_idle, 0, 0, 0, 14);
        add_entry(4, op_wait, 0, 0, 0, 2);
        add_entry(4, op_write, reg_all_low, 0, 3, 0);
        add_entry(4, op_write, reg_high_1, 0, 3, 0);
        add_entry(4, op_wait, 0, 0, 0, 0);
        add_entry(4, op_idle, 0, 0, 0, 8);
        // Lands the threshold strobe in the reload cycle
        add_entry(4, op_wait, 0, 0, 0, 4);
        add_entry(4, op_write, reg_low_0, 4, 0, 0);
        add_entry(4, op_idle, 0, 0, 0, 14);
        add_entry(5, op_write, reg_all_low, 3, 0, 0);
        add_entry(5, op_write, reg_all_high, 3, 0, 0);
        add_entry(5, op_wait, 0, 0, 0, 0);
        add_entry(5, op_idle, 0, 0, 0, 12);
        add_entry(6, op_write, reg_control, 0, 0, 0);
        add_entry(6, op_idle, 0, 0, 0, 3);
        add_entry(6, op_write, reg_low_2, 1, 0, 0);
        add_entry(6, op_write, reg_high_0, 0, 0, 0);
        add_entry(6, op_idle, 0, 0, 0, 4);

        repeat (8) @(posedge clock);
        reset <= 1'b1;

        test_errors = 0;
        foreach (table_op[i]) begin
            apply_entry(i);
            if (i == table_op.size() - 1 || table_test[i + 1] != table_test[i]) begin
                @(posedge clock);
                $display("test %0d done with %0d errors", table_test[i],
                         error_total - test_errors);
                test_errors = error_total;
            end
        end

        repeat (2) @(posedge clock);
        $display("%0d checks, %0d errors", check_total, error_total);
        if (error_total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* src/pwm_compare.sv */
//////////////////////////////////////////////////
// PWM compare unit
// Double-buffered low and high thresholds and the
// registered per-channel comparators
//////////////////////////////////////////////////

module pwm_compare #(
    parameter int COUNTER_WIDTH = 16
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [COUNTER_WIDTH-1:0]             count_value,
    input  logic                                 counter_stopped,
    input  logic                                 compare_we,
    input  pwm_pkg::compare_sel_e                compare_sel,
    input  logic [COUNTER_WIDTH-1:0]             compare_data,
    input  logic                                 reload_compare,
    output logic [pwm_pkg::compare_channels-1:0] match_low,
    output logic [pwm_pkg::compare_channels-1:0] match_high
);

    import pwm_pkg::*;

    logic [COUNTER_WIDTH-1:0] shadow_low   [compare_channels];
    logic [COUNTER_WIDTH-1:0] shadow_high  [compare_channels];
    logic [COUNTER_WIDTH-1:0] working_low  [compare_channels];
    logic [COUNTER_WIDTH-1:0] working_high [compare_channels];

    logic [compare_channels-1:0] write_low;
    logic [compare_channels-1:0] write_high;

    // Even register indices reset to 0, odd ones to all ones
    function automatic logic [COUNTER_WIDTH-1:0] reset_threshold(input int index);
        return {COUNTER_WIDTH{index[0]}};
    endfunction

    // Per-entry write enables, broadcast selects hit a whole group
    always_comb begin
        for (int c = 0; c < compare_channels; c++) begin
            write_low[c]  = compare_we &&
                            (compare_sel == compare_sel_e'(c) ||
                             compare_sel == sel_all_low);
            write_high[c] = compare_we &&
                            (compare_sel == compare_sel_e'(c + compare_channels) ||
                             compare_sel == sel_all_high);
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int c = 0; c < compare_channels; c++) begin
                shadow_low[c]   <= reset_threshold(c);
                working_low[c]  <= reset_threshold(c);
                shadow_high[c]  <= reset_threshold(c + compare_channels);
                working_high[c] <= reset_threshold(c + compare_channels);
            end
        end else begin
            for (int c = 0; c < compare_channels; c++) begin
                if (write_low[c]) begin
                    shadow_low[c] <= compare_data;
                end
                if (write_high[c]) begin
                    shadow_high[c] <= compare_data;
                end

                // Stopped writes bypass the shadow stage; running ones wait for reload
                if (counter_stopped && write_low[c]) begin
                    working_low[c] <= compare_data;
                end else if (reload_compare) begin
                    working_low[c] <= shadow_low[c];
                end
                if (counter_stopped && write_high[c]) begin
                    working_high[c] <= compare_data;
                end else if (reload_compare) begin
                    working_high[c] <= shadow_high[c];
                end
            end
        end
    end

    // Equality with a threshold sets neither flag
    always_ff @(posedge clock) begin
        if (!reset) begin
            match_low  <= '0;
            match_high <= '0;
        end else begin
            for (int c = 0; c < compare_channels; c++) begin
                match_low[c]  <= count_value < working_low[c];
                match_high[c] <= count_value > working_high[c];
            end
        end
    end

    // The counter only reloads while it is running
    no_reload_when_stopped: assert property (
        @(posedge clock) disable iff (!reset)
        reload_compare |-> !counter_stopped
    );

endmodule

/* src/pwm_counter.sv */
//////////////////////////////////////////////////
// PWM period counter
// Counts from 0 up to period and wraps, holds at 0
// while stopped and flags the first cycle after a wrap
//////////////////////////////////////////////////

module pwm_counter #(
    parameter int COUNTER_WIDTH = 16
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic [COUNTER_WIDTH-1:0]     period,
    input  logic                         run,
    output logic [COUNTER_WIDTH-1:0]     count_value,
    output logic                         counter_stopped,
    output logic                         reload_compare
);

    logic at_wrap;
    logic wrap_seen;

    // Greater-or-equal keeps the counter in range if period is lowered mid-count
    assign at_wrap = count_value >= period;

    assign counter_stopped = !run;

    always_ff @(posedge clock) begin
        if (!reset) begin
            count_value <= '0;
        end else if (!run) begin
            count_value <= '0;
        end else if (at_wrap) begin
            count_value <= '0;
        end else begin
            count_value <= count_value + 1'b1;
        end
    end

    // Set on the edge where the counter returns to 0 from period
    always_ff @(posedge clock) begin
        if (!reset) begin
            wrap_seen <= 1'b0;
        end else begin
            wrap_seen <= run && at_wrap;
        end
    end

    // A stop written on the wrap edge cancels the reload for that cycle
    assign reload_compare = wrap_seen && run;

    // With a steady period the count stays within the programmed range
    count_in_range: assert property (
        @(posedge clock) disable iff (!reset)
        run && $stable(period) |-> count_value <= period
    );

    reload_at_zero: assert property (
        @(posedge clock) disable iff (!reset)
        reload_compare |-> count_value == '0
    );

endmodule

/* src/pwm_pkg.sv */
//////////////////////////////////////////////////
// PWM timer shared definitions
// Bus register map, compare write selects and the
// number of channels in each threshold group
//////////////////////////////////////////////////

package pwm_pkg;

    // Channels per threshold group, so also the width of each match vector
    localparam int compare_channels = 3;

    // Bus register map. Addresses 0 to 7 map one to one onto compare_sel_e
    typedef enum logic [3:0] {
        reg_low_0    = 4'd0,
        reg_low_1    = 4'd1,
        reg_low_2    = 4'd2,
        reg_high_0   = 4'd3,
        reg_high_1   = 4'd4,
        reg_high_2   = 4'd5,
        reg_all_low  = 4'd6,
        reg_all_high = 4'd7,
        reg_period   = 4'd8,
        // Bit 0 of the data is the run bit
        reg_control  = 4'd9
    } pwm_reg_addr_e;

    // Threshold write select. The last two values write a whole group
    typedef enum logic [2:0] {
        sel_low_0    = 3'd0,
        sel_low_1    = 3'd1,
        sel_low_2    = 3'd2,
        sel_high_0   = 3'd3,
        sel_high_1   = 3'd4,
        sel_high_2   = 3'd5,
        sel_all_low  = 3'd6,
        sel_all_high = 3'd7
    } compare_sel_e;

endpackage

/* src/pwm_register_file.sv */
//////////////////////////////////////////////////
// PWM register file
// Decodes simple bus writes into the period, the
// run bit and a one-cycle threshold write strobe
//////////////////////////////////////////////////

module pwm_register_file #(
    parameter int COUNTER_WIDTH = 16
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         bus_we,
    input  pwm_pkg::pwm_reg_addr_e       bus_addr,
    input  logic [COUNTER_WIDTH-1:0]     bus_data,
    output logic [COUNTER_WIDTH-1:0]     period,
    output logic                         run,
    output logic                         compare_we,
    output pwm_pkg::compare_sel_e        compare_sel,
    output logic [COUNTER_WIDTH-1:0]     compare_data
);

    import pwm_pkg::*;

    logic compare_hit;

    // Addresses 0 to 7 are threshold writes, anything above reg_control is dropped
    always_comb begin
        case (bus_addr)
            reg_low_0,
            reg_low_1,
            reg_low_2,
            reg_high_0,
            reg_high_1,
            reg_high_2,
            reg_all_low,
            reg_all_high: compare_hit = 1'b1;
            default:      compare_hit = 1'b0;
        endcase
    end

    // Period and run are plain level registers
    always_ff @(posedge clock) begin
        if (!reset) begin
            period <= {COUNTER_WIDTH{1'b1}};
            run    <= 1'b0;
        end else if (bus_we) begin
            if (bus_addr == reg_period) begin
                period <= bus_data;
            end
            if (bus_addr == reg_control) begin
                run <= bus_data[0];
            end
        end
    end

    // The strobe is high for exactly one cycle per accepted threshold write
    always_ff @(posedge clock) begin
        if (!reset) begin
            compare_we <= 1'b0;
        end else begin
            compare_we <= bus_we && compare_hit;
        end
    end

    // Select and data only matter while the strobe is high
    always_ff @(posedge clock) begin
        if (bus_we && compare_hit) begin
            compare_sel  <= compare_sel_e'(bus_addr[2:0]);
            compare_data <= bus_data;
        end
    end

    // Every strobe cycle needs a bus write into the threshold range on the edge before
    strobe_from_bus_write: assert property (
        @(posedge clock) disable iff (!reset)
        compare_we |-> $past(bus_we) && $past(bus_addr) <= reg_all_high
    );

endmodule

/* src/pwm_timer.sv */
//////////////////////////////////////////////////
// Three-channel PWM timer
// Register file, period counter and compare unit
//////////////////////////////////////////////////

module pwm_timer #(
    parameter int COUNTER_WIDTH = 16
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 bus_we,
    input  pwm_pkg::pwm_reg_addr_e               bus_addr,
    input  logic [COUNTER_WIDTH-1:0]             bus_data,
    output logic [COUNTER_WIDTH-1:0]             count_value,
    output logic [pwm_pkg::compare_channels-1:0] match_low,
    output logic [pwm_pkg::compare_channels-1:0] match_high
);

    import pwm_pkg::*;

    logic [COUNTER_WIDTH-1:0] period;
    logic                     run;
    logic                     compare_we;
    compare_sel_e             compare_sel;
    logic [COUNTER_WIDTH-1:0] compare_data;
    logic                     counter_stopped;
    logic                     reload_compare;

    pwm_register_file #(
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) register_file (
        .clock       (clock),
        .reset       (reset),
        .bus_we      (bus_we),
        .bus_addr    (bus_addr),
        .bus_data    (bus_data),
        .period      (period),
        .run         (run),
        .compare_we  (compare_we),
        .compare_sel (compare_sel),
        .compare_data(compare_data)
    );

    pwm_counter #(
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) counter (
        .clock          (clock),
        .reset          (reset),
        .period         (period),
        .run            (run),
        .count_value    (count_value),
        .counter_stopped(counter_stopped),
        .reload_compare (reload_compare)
    );

    pwm_compare #(
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) compare (
        .clock          (clock),
        .reset          (reset),
        .count_value    (count_value),
        .counter_stopped(counter_stopped),
        .compare_we     (compare_we),
        .compare_sel    (compare_sel),
        .compare_data   (compare_data),
        .reload_compare (reload_compare),
        .match_low      (match_low),
        .match_high     (match_high)
    );

endmodule
